//--- Makefile
# Verilator build and run for the fetch front end

TOP = tb_fetch

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

# the memory model loads program.hex from the working directory
run: build
	cp sim/program.hex program.hex
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "Test OK" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module fetch_top -f filelist.f

clean:
	rm -rf obj_dir sim.log program.hex

//--- filelist.f
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/inst_fetch.sv
hw/inst_sram.sv
hw/inst_predecode.sv
hw/fetch_top.sv
sim/tb_fetch.sv

//--- hw/fetch_pkg.sv
// Fetch front end shared definitions
`default_nettype none

package fetch_pkg;

    // datapath and memory sizes
    localparam int XLEN = 32;
    localparam int MEM_WORDS = 16;
    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // cycles from the accepted address to rvalid
    localparam int SRAM_WAIT = 2;
    localparam int WAIT_W = $clog2(SRAM_WAIT + 1);

    // AXI response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        idle,
        wait_data,
        drop
    } fetch_state_e;

    // major opcode, inst[6:2]
    typedef enum logic [4:0] {
        opc_load   = 5'b00000,
        opc_op_imm = 5'b00100,
        opc_auipc  = 5'b00101,
        opc_store  = 5'b01000,
        opc_op     = 5'b01100,
        opc_lui    = 5'b01101,
        opc_branch = 5'b11000,
        opc_jalr   = 5'b11001,
        opc_jal    = 5'b11011,
        opc_system = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_jump,
        op_system,
        op_illegal,
        op_fault
    } op_class_e;

    typedef struct packed {
        logic [XLEN-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
        logic [1:0]      resp;
    } axi_r_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        logic            bus_err;
    } fetch_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        op_class_e       op_class;
    } pred_out_t;

endpackage

`default_nettype wire

//--- hw/fetch_top.sv
// Instruction fetch front end
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            redirect_valid,
    input  wire logic [XLEN-1:0] redirect_pc,
    output logic                 out_valid,
    output pred_out_t            out,
    input  wire logic            out_ready
);

    logic            pc_valid;
    logic [XLEN-1:0] pc;
    logic            pc_ready;

    // AXI4-Lite read channels
    logic            arvalid;
    logic            arready;
    axi_ar_t         ar;
    logic            rvalid;
    logic            rready;
    axi_r_t          r;

    logic            pkt_valid;
    fetch_pkt_t      pkt;
    logic            pkt_ready;

    pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc_valid       (pc_valid),
        .pc             (pc),
        .pc_ready       (pc_ready)
    );

    inst_fetch u_inst_fetch (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .pc_valid       (pc_valid),
        .pc             (pc),
        .pc_ready       (pc_ready),
        .arvalid        (arvalid),
        .arready        (arready),
        .ar             (ar),
        .rvalid         (rvalid),
        .rready         (rready),
        .r              (r),
        .pkt_valid      (pkt_valid),
        .pkt            (pkt),
        .pkt_ready      (pkt_ready)
    );

    inst_sram u_inst_sram (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

    inst_predecode u_inst_predecode (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .pkt_valid      (pkt_valid),
        .pkt            (pkt),
        .pkt_ready      (pkt_ready),
        .out_valid      (out_valid),
        .out            (out),
        .out_ready      (out_ready)
    );

endmodule

`default_nettype wire

//--- hw/inst_fetch.sv
// AXI4-Lite instruction fetch master
`timescale 1ns/100ps
`default_nettype none

module inst_fetch import fetch_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            redirect_valid,
    input  wire logic            pc_valid,
    input  wire logic [XLEN-1:0] pc,
    output logic                 pc_ready,
    output logic                 arvalid,
    input  wire logic            arready,
    output axi_ar_t              ar,
    input  wire logic            rvalid,
    output logic                 rready,
    input  wire axi_r_t          r,
    output logic                 pkt_valid,
    output fetch_pkt_t           pkt,
    input  wire logic            pkt_ready
);

    fetch_state_e    state;
    fetch_state_e    state_next;
    logic [XLEN-1:0] pc_q;
    logic            slot_free;
    logic            ar_hs;
    logic            r_hs;

    // only issue when the result will have somewhere to go
    assign slot_free = !pkt_valid || pkt_ready;
    assign arvalid = (state == idle) && pc_valid && slot_free;
    assign ar = '{addr: pc};
    assign ar_hs = arvalid && arready;
    assign pc_ready = ar_hs;

    assign rready = (state == wait_data) || (state == drop);
    assign r_hs = rvalid && rready;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                // address sent in the redirect cycle is already stale
                if (ar_hs) begin
                    state_next = redirect_valid ? drop : wait_data;
                end
            end
            wait_data: begin
                if (r_hs) begin
                    state_next = idle;
                end else if (redirect_valid) begin
                    state_next = drop;
                end
            end
            drop: begin
                if (r_hs) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // pc of the read on the bus, paired with its data later
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            pc_q <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect_valid) begin
            pkt_valid <= 1'b0;
        end else if (state == wait_data && r_hs) begin
            pkt_valid <= 1'b1;
        end else if (pkt_ready) begin
            pkt_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == wait_data && r_hs) begin
            pkt.pc <= pc_q;
            pkt.inst <= r.data;
            pkt.bus_err <= (r.resp != RESP_OKAY);
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid);

endmodule

`default_nettype wire

//--- hw/inst_predecode.sv
// Instruction class predecode
`timescale 1ns/100ps
`default_nettype none

module inst_predecode import fetch_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       redirect_valid,
    input  wire logic       pkt_valid,
    input  wire fetch_pkt_t pkt,
    output logic            pkt_ready,
    output logic            out_valid,
    output pred_out_t       out,
    input  wire logic       out_ready
);

    function automatic op_class_e classify(input fetch_pkt_t p);
        op_class_e cls;
        cls = op_illegal;
        if (p.bus_err) begin
            cls = op_fault;
        end else if (p.inst[1:0] == 2'b11) begin
            case (p.inst[6:2])
                opc_op, opc_op_imm, opc_lui, opc_auipc: cls = op_alu;
                opc_load:                               cls = op_load;
                opc_store:                              cls = op_store;
                opc_branch:                             cls = op_branch;
                opc_jal, opc_jalr:                      cls = op_jump;
                opc_system:                             cls = op_system;
                default:                                cls = op_illegal;
            endcase
        end
        return cls;
    endfunction

    // slot takes a new packet when empty or emptying
    assign pkt_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst || redirect_valid) begin
            out_valid <= 1'b0;
        end else if (pkt_valid && pkt_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_valid && pkt_ready) begin
            out.pc <= pkt.pc;
            out.inst <= pkt.inst;
            out.op_class <= classify(pkt);
        end
    end

endmodule

`default_nettype wire

//--- hw/inst_sram.sv
// Read-only instruction memory
`timescale 1ns/100ps
`default_nettype none

module inst_sram import fetch_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    arvalid,
    output logic         arready,
    input  wire axi_ar_t ar,
    output logic         rvalid,
    input  wire logic    rready,
    output axi_r_t       r
);

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic [XLEN-1:0]   addr_q;
    logic [WAIT_W-1:0] wait_cnt;
    logic              busy;
    logic              in_range;

    initial begin
        $readmemh("program.hex", mem);
    end

    // one read at a time
    assign arready = !busy;
    assign rvalid = busy && (wait_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            wait_cnt <= '0;
        end else if (arvalid && arready) begin
            busy <= 1'b1;
            wait_cnt <= WAIT_W'(SRAM_WAIT - 1);
        end else if (rvalid && rready) begin
            busy <= 1'b0;
        end else if (busy && wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            addr_q <= ar.addr;
        end
    end

    // anything past the last word answers with SLVERR
    assign in_range = addr_q < XLEN'(MEM_WORDS * 4);

    always_comb begin
        if (in_range) begin
            r.data = mem[addr_q[IDX_W+1:2]];
            r.resp = RESP_OKAY;
        end else begin
            r.data = '0;
            r.resp = RESP_SLVERR;
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(r));

endmodule

`default_nettype wire

//--- hw/pc_gen.sv
// Program counter generator
`timescale 1ns/100ps
`default_nettype none

module pc_gen import fetch_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            redirect_valid,
    input  wire logic [XLEN-1:0] redirect_pc,
    output logic                 pc_valid,
    output logic [XLEN-1:0]      pc,
    input  wire logic            pc_ready
);

    // valid comes up on the first cycle out of reset and stays there
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_valid <= 1'b0;
        end else begin
            pc_valid <= 1'b1;
        end
    end

    // redirect wins over a transfer in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (pc_valid && pc_ready) begin
            pc <= pc + XLEN'(4);
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- sim/program.hex
// one 32-bit instruction word per line, address 0 first
00000013
00112023
00012083
00208463
008000ef
00008067
00000073
123450b7
00001097
002081b3
00004501
0000000b
00310113
0040a183
00100073
fe000ee3

//--- sim/tb_fetch.sv
// Fetch front end testbench
`timescale 1ns/100ps
`default_nettype none

module tb_fetch import fetch_pkg::*; ();

    logic            clk;
    logic            rst;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    logic            out_valid;
    pred_out_t       out;
    logic            out_ready;

    // reference copy of the memory image
    logic [XLEN-1:0] image [MEM_WORDS];
    logic [31:0]     lfsr;
    logic [XLEN-1:0] next_pc;
    logic            stall_seen;
    pred_out_t       held;
    pred_out_t       got;

    fetch_top UUT (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_valid      (out_valid),
        .out            (out),
        .out_ready      (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic op_class_e class_of(input logic [XLEN-1:0] word);
        op_class_e cls;
        cls = op_illegal;
        if (word[1:0] == 2'b11) begin
            case (word[6:0])
                7'h33, 7'h13, 7'h37, 7'h17: cls = op_alu;
                7'h03:                      cls = op_load;
                7'h23:                      cls = op_store;
                7'h63:                      cls = op_branch;
                7'h6f, 7'h67:               cls = op_jump;
                7'h73:                      cls = op_system;
                default:                    cls = op_illegal;
            endcase
        end
        return cls;
    endfunction

    function automatic logic in_memory(input logic [XLEN-1:0] pc);
        return pc < XLEN'(MEM_WORDS * 4);
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [XLEN-1:0] actual,
                         input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // one accepted output; out_ready is either held high or taken from the lfsr
    task automatic wait_out(input logic random_ready, output pred_out_t item);
        int   cycles;
        logic taken;
        logic ready_bit;
        cycles = 0;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            if (stall_seen) begin
                check("out_valid", XLEN'(out_valid), XLEN'(1'b1));
                check("out.pc", out.pc, held.pc);
                check("out.inst", out.inst, held.inst);
                check("out.op_class", XLEN'(out.op_class), XLEN'(held.op_class));
            end
            if (random_ready) begin
                lfsr = lfsr_step(lfsr);
                ready_bit = lfsr[0];
            end else begin
                ready_bit = 1'b1;
            end
            out_ready = ready_bit;
            stall_seen = out_valid && !ready_bit;
            held = out;
            if (out_valid && ready_bit) begin
                item = out;
                taken = 1'b1;
            end else begin
                cycles++;
                if (cycles >= 100) begin
                    $display("no output arrived within 100 cycles at %0t", $time);
                    abort_run();
                end
            end
        end
    endtask

    task automatic expect_stream(input int count, input logic random_ready);
        op_class_e cls;
        for (int i = 0; i < count; i++) begin
            wait_out(random_ready, got);
            cls = in_memory(next_pc) ? class_of(image[next_pc[IDX_W+1:2]]) : op_fault;
            check("out.pc", got.pc, next_pc);
            check("out.inst", got.inst,
                  in_memory(next_pc) ? image[next_pc[IDX_W+1:2]] : '0);
            check("out.op_class", XLEN'(got.op_class), XLEN'(cls));
            next_pc = next_pc + 4;
        end
    endtask

    task automatic redirect_to(input logic [XLEN-1:0] target);
        @(negedge clk);
        redirect_valid = 1'b1;
        redirect_pc = target;
        out_ready = 1'b0;
        stall_seen = 1'b0;
        @(negedge clk);
        redirect_valid = 1'b0;
        next_pc = target;
    endtask

    task automatic test_reset();
        repeat (10) begin
            @(negedge clk);
            check("out_valid", XLEN'(out_valid), XLEN'(1'b0));
        end
        rst = 1'b0;
        @(negedge clk);
        check("out_valid", XLEN'(out_valid), XLEN'(1'b0));
        next_pc = RESET_PC;
    endtask

    task automatic test_sequential();
        expect_stream(MEM_WORDS, 1'b0);
    endtask

    task automatic test_backpressure();
        redirect_to(32'd0);
        expect_stream(24, 1'b1);
    endtask

    task automatic test_redirect_mid();
        expect_stream(3, 1'b1);
        redirect_to(32'd32);
        expect_stream(8, 1'b1);
    endtask

    task automatic test_fault();
        redirect_to(32'd64);
        for (int i = 0; i < 2; i++) begin
            wait_out(1'b0, got);
            check("out.pc", got.pc, next_pc);
            check("out.inst", got.inst, '0);
            check("out.op_class", XLEN'(got.op_class), XLEN'(op_fault));
            next_pc = next_pc + 4;
        end
        redirect_to(32'd0);
        expect_stream(4, 1'b0);
    endtask

    initial begin
        rst = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        out_ready = 1'b0;
        lfsr = 32'h5ebced5a;
        stall_seen = 1'b0;
        next_pc = RESET_PC;
        $readmemh("sim/program.hex", image);
        if ($isunknown(image[0])) begin
            $display("program image sim/program.hex could not be read");
            abort_run();
        end
        test_reset();
        test_sequential();
        test_backpressure();
        test_redirect_mid();
        test_fault();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
